// ==== hw/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// register file geometry
`define CSR_ADDR_W 14
`define CSR_DATA_W 32

// scratch registers, 1 to 16 of them
`define CSR_NUM_SAVE 4

// {pg,da} out of reset, direct translation
`define CSR_RST_TRANSLATE 2'b01

// field widths
`define CSR_ECFG_LIE_W 13
`define CSR_ESTAT_SUB_W 9

// ticlr clear bit
`define CSR_TICLR_CLR 0

`endif

// ==== hw/csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

    // address map
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 'h00,
        CSR_PRMD   = 'h01,
        CSR_ECFG   = 'h04,
        CSR_ESTAT  = 'h05,
        CSR_ERA    = 'h06,
        CSR_EENTRY = 'h0c,
        CSR_SAVE0  = 'h30,
        CSR_SAVE1  = 'h31,
        CSR_SAVE2  = 'h32,
        CSR_SAVE3  = 'h33,
        CSR_TCFG   = 'h41,
        CSR_TVAL   = 'h42,
        CSR_TICLR  = 'h44
    } csr_addr_e;

    // {pg,da}
    typedef enum logic [1:0] {
        TR_DIRECT = 2'b01,
        TR_PAGED  = 2'b10
    } translate_e;

    typedef struct packed {
        logic                   valid;
        csr_addr_e              addr;
        logic [`CSR_DATA_W-1:0] mask;
        logic [`CSR_DATA_W-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic                   store;
        logic                   restore;
        logic                   ecode_we;
        logic [6:0]             ecode;
        logic                   era_we;
        logic [`CSR_DATA_W-1:0] era;
    } trap_t;

    typedef struct packed {
        logic                     crmd;
        logic                     prmd;
        logic                     ecfg;
        logic                     estat;
        logic                     era;
        logic                     eentry;
        logic [`CSR_NUM_SAVE-1:0] save;
        logic                     tcfg;
        logic                     ticlr;
    } csr_sel_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] crmd;
        logic [`CSR_DATA_W-1:0] prmd;
        logic [`CSR_DATA_W-1:0] ecfg;
        logic [`CSR_DATA_W-1:0] estat;
        logic [`CSR_DATA_W-1:0] era;
        logic [`CSR_DATA_W-1:0] eentry;
    } exc_view_t;

endpackage

// ==== hw/csr_write_decode.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_write_decode (
    input  csr_pkg::csr_wr_t  wr,
    output csr_pkg::csr_sel_t sel
);

    always_comb begin
        sel = '0;
        sel.crmd   = wr.valid && (wr.addr == csr_pkg::CSR_CRMD);
        sel.prmd   = wr.valid && (wr.addr == csr_pkg::CSR_PRMD);
        sel.ecfg   = wr.valid && (wr.addr == csr_pkg::CSR_ECFG);
        sel.estat  = wr.valid && (wr.addr == csr_pkg::CSR_ESTAT);
        sel.era    = wr.valid && (wr.addr == csr_pkg::CSR_ERA);
        sel.eentry = wr.valid && (wr.addr == csr_pkg::CSR_EENTRY);
        sel.tcfg   = wr.valid && (wr.addr == csr_pkg::CSR_TCFG);
        sel.ticlr  = wr.valid && (wr.addr == csr_pkg::CSR_TICLR);
        // save window is contiguous from SAVE0
        for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
            sel.save[i] = wr.valid && (wr.addr == (csr_pkg::CSR_SAVE0 + i));
        end
    end

    // at most one register takes a given write
    always_comb begin
        assert final ($onehot0(sel))
        else $error("write decode selected more than one register");
    end

endmodule

// ==== hw/csr_save_reg.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_save_reg (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   sel,
    input  logic [`CSR_DATA_W-1:0] mask,
    input  logic [`CSR_DATA_W-1:0] data,
    output logic [`CSR_DATA_W-1:0] value
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            value <= '0;
        end else if (sel) begin
            value <= (value & ~mask) | (data & mask);
        end
    end

    a_hold_unselected: assert property (@(posedge clk) disable iff (!rstn)
        (rstn && !sel) |=> $stable(value))
    else $error("save register changed without select");

endmodule

// ==== hw/csr_exc_state.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_exc_state (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_sel_t      sel,
    input  logic [`CSR_DATA_W-1:0] mask,
    input  logic [`CSR_DATA_W-1:0] data,
    input  csr_pkg::trap_t         trap,
    input  logic [7:0]             hardware_int,
    input  logic                   timer_int,
    output csr_pkg::exc_view_t     view,
    output logic [1:0]             plv,
    output logic [5:0]             ecode,
    output csr_pkg::translate_e    translate_mode,
    output logic                   has_interrupt_cpu,
    output logic                   has_interrupt_idle
);

    logic [1:0]                     crmd_plv;
    logic                           crmd_ie;
    logic [1:0]                     crmd_pgda;
    logic [1:0]                     crmd_datf;
    logic [1:0]                     crmd_datm;
    logic [1:0]                     prmd_pplv;
    logic                           prmd_pie;
    logic [`CSR_ECFG_LIE_W-1:0]     ecfg_lie;
    logic [1:0]                     estat_sw;
    logic [5:0]                     estat_ecode;
    logic [`CSR_ESTAT_SUB_W-1:0]    estat_sub;
    logic [`CSR_DATA_W-1:0]         era_q;
    logic [25:0]                    eentry_va;
    logic [`CSR_ECFG_LIE_W-1:0]     int_status;
    logic [`CSR_DATA_W-1:0]         crmd_mrg;
    logic [`CSR_DATA_W-1:0]         prmd_mrg;
    logic [`CSR_DATA_W-1:0]         ecfg_mrg;
    logic [`CSR_DATA_W-1:0]         estat_mrg;
    logic [`CSR_DATA_W-1:0]         era_mrg;
    logic [`CSR_DATA_W-1:0]         eentry_mrg;

    function automatic logic [`CSR_DATA_W-1:0] merge(input logic [`CSR_DATA_W-1:0] old,
                                                     input logic [`CSR_DATA_W-1:0] m,
                                                     input logic [`CSR_DATA_W-1:0] d);
        merge = (old & ~m) | (d & m);
    endfunction

    // sw[1:0], hwi[9:2], timer at 11
    assign int_status = {1'b0, timer_int, 1'b0, hardware_int, estat_sw};

    ////////////////////////////////////////////////////////////
    // word assembly
    always_comb begin
        view = '0;
        view.crmd[1:0]    = crmd_plv;
        view.crmd[2]      = crmd_ie;
        view.crmd[4:3]    = crmd_pgda;
        view.crmd[6:5]    = crmd_datf;
        view.crmd[8:7]    = crmd_datm;
        view.prmd[1:0]    = prmd_pplv;
        view.prmd[2]      = prmd_pie;
        view.ecfg[12:0]   = ecfg_lie;
        view.estat[12:0]  = int_status;
        view.estat[21:16] = estat_ecode;
        view.estat[30:22] = estat_sub;
        view.era          = era_q;
        view.eentry[31:6] = eentry_va;
    end

    assign crmd_mrg   = merge(view.crmd, mask, data);
    assign prmd_mrg   = merge(view.prmd, mask, data);
    assign ecfg_mrg   = merge(view.ecfg, mask, data);
    assign estat_mrg  = merge(view.estat, mask, data);
    assign era_mrg    = merge(view.era, mask, data);
    assign eentry_mrg = merge(view.eentry, mask, data);

    ////////////////////////////////////////////////////////////
    // registers
    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_pgda <= `CSR_RST_TRANSLATE;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (trap.restore) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (trap.store) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (sel.crmd) begin
            crmd_plv  <= crmd_mrg[1:0];
            crmd_ie   <= crmd_mrg[2];
            crmd_datf <= crmd_mrg[6:5];
            crmd_datm <= crmd_mrg[8:7];
            // only one of pg and da may be set
            if (crmd_mrg[4] ^ crmd_mrg[3]) begin
                crmd_pgda <= crmd_mrg[4:3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (trap.store) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (sel.prmd) begin
            prmd_pplv <= prmd_mrg[1:0];
            prmd_pie  <= prmd_mrg[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_lie <= '0;
        end else if (sel.ecfg) begin
            // lie[10] has no source
            ecfg_lie <= ecfg_mrg[12:0] & 13'h1bff;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            estat_sw    <= '0;
            estat_ecode <= '0;
            estat_sub   <= '0;
        end else if (trap.ecode_we) begin
            estat_ecode <= trap.ecode[5:0];
            // subcode only for a real exception code
            estat_sub <= (|trap.ecode[5:0]) ? {8'b0, trap.ecode[6]} : '0;
        end else if (sel.estat) begin
            estat_sw <= estat_mrg[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era_q <= '0;
        end else if (trap.era_we) begin
            era_q <= trap.era;
        end else if (sel.era) begin
            era_q <= era_mrg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_va <= '0;
        end else if (sel.eentry) begin
            eentry_va <= eentry_mrg[31:6];
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    assign plv                = crmd_plv;
    assign ecode              = estat_ecode;
    assign translate_mode     = csr_pkg::translate_e'(crmd_pgda);
    assign has_interrupt_idle = |int_status;
    assign has_interrupt_cpu  = crmd_ie & (|(ecfg_lie & int_status));

    a_translate_legal: assert property (@(posedge clk) disable iff (!rstn)
        translate_mode inside {csr_pkg::TR_DIRECT, csr_pkg::TR_PAGED})
    else $error("illegal translate mode %b", translate_mode);

endmodule

// ==== hw/csr_timer.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_sel_t      sel,
    input  logic [`CSR_DATA_W-1:0] mask,
    input  logic [`CSR_DATA_W-1:0] data,
    output logic [`CSR_DATA_W-1:0] tcfg,
    output logic [`CSR_DATA_W-1:0] tval,
    output logic                   timer_int
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic        reload;
    logic        timeout;
    logic        clr;
    logic [`CSR_DATA_W-1:0] tcfg_mrg;

    assign tcfg     = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_mrg = (tcfg & ~mask) | (data & mask);
    assign clr      = sel.ticlr && mask[`CSR_TICLR_CLR] && data[`CSR_TICLR_CLR];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (sel.tcfg) begin
            tcfg_en       <= tcfg_mrg[0];
            tcfg_periodic <= tcfg_mrg[1];
            tcfg_initval  <= tcfg_mrg[31:2];
        end
    end

    // any tcfg write restarts the count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reload <= 1'b0;
        end else begin
            reload <= sel.tcfg && (|mask);
        end
    end

    ////////////////////////////////////////////////////////////
    // countdown, loaded one above initval so zero still fires
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval    <= '0;
            timeout <= 1'b0;
        end else if (tval == '0 || reload) begin
            timeout <= 1'b0;
            if (tcfg_periodic || reload) begin
                tval <= {tcfg_initval, 2'b01};
            end
        end else if (tcfg_en) begin
            tval    <= tval - 1'b1;
            timeout <= (tval == 32'd1);
        end
    end

    // sticky until cleared, clear wins
    always_ff @(posedge clk) begin
        if (!rstn || clr) begin
            timer_int <= 1'b0;
        end else if (timeout) begin
            timer_int <= 1'b1;
        end
    end

    a_int_after_timeout: assert property (@(posedge clk) disable iff (!rstn)
        $rose(timer_int) |-> $past(timeout))
    else $error("timer interrupt rose without a timeout");

endmodule

// ==== hw/csr_read_mux.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_e                          raddr_a,
    input  csr_pkg::csr_addr_e                          raddr_b,
    input  csr_pkg::exc_view_t                          view,
    input  logic [`CSR_NUM_SAVE-1:0][`CSR_DATA_W-1:0]   save,
    input  logic [`CSR_DATA_W-1:0]                      tcfg,
    input  logic [`CSR_DATA_W-1:0]                      tval,
    output logic [`CSR_DATA_W-1:0]                      rdata_a,
    output logic [`CSR_DATA_W-1:0]                      rdata_b
);

    function automatic logic [`CSR_DATA_W-1:0] read_one(input csr_pkg::csr_addr_e a);
        logic [`CSR_DATA_W-1:0] word;
        word = '0;
        case (a)
            csr_pkg::CSR_CRMD:   word = view.crmd;
            csr_pkg::CSR_PRMD:   word = view.prmd;
            csr_pkg::CSR_ECFG:   word = view.ecfg;
            csr_pkg::CSR_ESTAT:  word = view.estat;
            csr_pkg::CSR_ERA:    word = view.era;
            csr_pkg::CSR_EENTRY: word = view.eentry;
            csr_pkg::CSR_TCFG:   word = tcfg;
            csr_pkg::CSR_TVAL:   word = tval;
            // write-only clear
            csr_pkg::CSR_TICLR:  word = '0;
            default:             word = '0;
        endcase
        for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
            if (a == (csr_pkg::CSR_SAVE0 + i)) begin
                word = save[i];
            end
        end
        return word;
    endfunction

    // two independent ports
    always_comb begin
        rdata_a = read_one(raddr_a);
    end

    always_comb begin
        rdata_b = read_one(raddr_b);
    end

endmodule

// ==== hw/csr_top.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_wr_t       wr,
    input  csr_pkg::trap_t         trap,
    input  logic [7:0]             hardware_int,
    input  csr_pkg::csr_addr_e     raddr_a,
    input  csr_pkg::csr_addr_e     raddr_b,
    output logic [`CSR_DATA_W-1:0] rdata_a,
    output logic [`CSR_DATA_W-1:0] rdata_b,
    output logic [1:0]             plv,
    output logic [5:0]             ecode,
    output logic [`CSR_DATA_W-1:0] era_out,
    output logic [`CSR_DATA_W-1:0] eentry,
    output csr_pkg::translate_e    translate_mode,
    output logic                   has_interrupt_cpu,
    output logic                   has_interrupt_idle
);

    csr_pkg::csr_sel_t                          sel;
    csr_pkg::exc_view_t                         view;
    logic [`CSR_NUM_SAVE-1:0][`CSR_DATA_W-1:0]  save_q;
    logic [`CSR_DATA_W-1:0]                     tcfg;
    logic [`CSR_DATA_W-1:0]                     tval;
    logic                                       timer_int;

    csr_write_decode u_decode (
        .wr  (wr),
        .sel (sel)
    );

    csr_exc_state u_exc (
        .clk                (clk),
        .rstn               (rstn),
        .sel                (sel),
        .mask               (wr.mask),
        .data               (wr.data),
        .trap               (trap),
        .hardware_int       (hardware_int),
        .timer_int          (timer_int),
        .view               (view),
        .plv                (plv),
        .ecode              (ecode),
        .translate_mode     (translate_mode),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .sel       (sel),
        .mask      (wr.mask),
        .data      (wr.data),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    ////////////////////////////////////////////////////////////
    // scratch bank
    for (genvar i = 0; i < `CSR_NUM_SAVE; i++) begin : g_save
        csr_save_reg u_save (
            .clk   (clk),
            .rstn  (rstn),
            .sel   (sel.save[i]),
            .mask  (wr.mask),
            .data  (wr.data),
            .value (save_q[i])
        );
    end

    csr_read_mux u_rmux (
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .view    (view),
        .save    (save_q),
        .tcfg    (tcfg),
        .tval    (tval),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign era_out = view.era;
    assign eentry  = view.eentry;

endmodule

// ==== dv/csr_tb.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_tb;

    localparam int TIMER_IV  = 3;
    localparam int LATENCY   = 4 * TIMER_IV + 4;
    localparam int RUN_CYC   = 8 + 30 + 20 + 12 + 12 + 3 * LATENCY + 30 + 10 + 12;
    localparam int WD_NS     = (RUN_CYC + 200) * 8;

    logic clk;
    logic rstn;
    csr_pkg::csr_wr_t wr;
    csr_pkg::trap_t trap;
    logic [7:0] hardware_int;
    csr_pkg::csr_addr_e raddr_a;
    csr_pkg::csr_addr_e raddr_b;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    logic [1:0] plv;
    logic [5:0] ecode;
    logic [31:0] era_out;
    logic [31:0] eentry;
    csr_pkg::translate_e translate_mode;
    logic has_interrupt_cpu;
    logic has_interrupt_idle;

    // expected values and the enables that arm each check
    logic chk_rd, chk_tr, chk_plv, chk_ecode, chk_era, chk_int, chk_tmr, chk_eentry;
    logic [31:0] exp_a, exp_b, exp_era, exp_eentry;
    logic [1:0] exp_plv;
    logic [5:0] exp_ecode;
    csr_pkg::translate_e exp_tr;
    logic exp_cpu, exp_idle;
    logic [31:0] save_m [`CSR_NUM_SAVE];
    int cyc, t0, err_count, err_mark, pass_tests, fail_tests;
    integer seed;

    csr_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////
    // checkers
    a_rd_a: assert property (@(posedge clk) disable iff (!rstn)
        chk_rd |-> rdata_a == exp_a)
    else begin
        $display("** Error: %0t rdata_a %h expected %h", $time, $sampled(rdata_a), exp_a);
        err_count++;
    end
    a_rd_b: assert property (@(posedge clk) disable iff (!rstn)
        chk_rd |-> rdata_b == exp_b)
    else begin
        $display("** Error: %0t rdata_b %h expected %h", $time, $sampled(rdata_b), exp_b);
        err_count++;
    end
    a_tr: assert property (@(posedge clk) disable iff (!rstn)
        chk_tr |-> translate_mode == exp_tr)
    else begin
        $display("** Error: %0t translate %b expected %b", $time,
                 $sampled(translate_mode), exp_tr);
        err_count++;
    end
    a_plv: assert property (@(posedge clk) disable iff (!rstn)
        chk_plv |-> plv == exp_plv)
    else begin
        $display("** Error: %0t plv %0d expected %0d", $time, $sampled(plv), exp_plv);
        err_count++;
    end
    a_ecode: assert property (@(posedge clk) disable iff (!rstn)
        chk_ecode |-> ecode == exp_ecode)
    else begin
        $display("** Error: %0t ecode %h expected %h", $time, $sampled(ecode), exp_ecode);
        err_count++;
    end
    a_era: assert property (@(posedge clk) disable iff (!rstn)
        chk_era |-> era_out == exp_era)
    else begin
        $display("** Error: %0t era %h expected %h", $time, $sampled(era_out), exp_era);
        err_count++;
    end
    a_eentry: assert property (@(posedge clk) disable iff (!rstn)
        chk_eentry |-> eentry == exp_eentry)
    else begin
        $display("** Error: %0t eentry %h expected %h", $time, $sampled(eentry), exp_eentry);
        err_count++;
    end
    a_int: assert property (@(posedge clk) disable iff (!rstn)
        chk_int |-> (has_interrupt_cpu == exp_cpu && has_interrupt_idle == exp_idle))
    else begin
        $display("** Error: %0t cpu/idle %b%b expected %b%b", $time,
                 $sampled(has_interrupt_cpu), $sampled(has_interrupt_idle), exp_cpu, exp_idle);
        err_count++;
    end
    // interrupt latency counted from the TCFG write cycle
    a_tmr: assert property (@(posedge clk) disable iff (!rstn)
        (chk_tmr && $rose(has_interrupt_idle)) |-> (cyc - t0 == LATENCY))
    else begin
        $display("** Error: %0t timer latency %0d expected %0d", $time,
                 $sampled(cyc) - t0, LATENCY);
        err_count++;
    end

    ////////////////////////////////////////////////////////////
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic sw_write(input csr_pkg::csr_addr_e a,
                            input logic [31:0] m,
                            input logic [31:0] d);
        wr.valid = 1'b1;
        wr.addr  = a;
        wr.mask  = m;
        wr.data  = d;
        tick();
        wr.valid = 1'b0;
    endtask

    task automatic check_read(input csr_pkg::csr_addr_e a, input logic [31:0] ea,
                              input csr_pkg::csr_addr_e b, input logic [31:0] eb);
        raddr_a = a;
        raddr_b = b;
        exp_a   = ea;
        exp_b   = eb;
        chk_rd  = 1'b1;
        tick();
        chk_rd  = 1'b0;
    endtask

    task automatic wait_for_idle(input int max_cyc);
        int n;
        n = 0;
        tick();
        while (!has_interrupt_idle && n < max_cyc) begin
            tick();
            n++;
        end
        if (!has_interrupt_idle) begin
            $display("timer interrupt did not rise within %0d cycles", max_cyc);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == err_mark) begin
            pass_tests++;
            $display("test %s: pass", name);
        end else begin
            fail_tests++;
            $display("test %s: fail, %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    initial begin
        #(WD_NS);
        $display("watchdog: run timed out after %0d ns", WD_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int idx;
        logic [31:0] m, d;
        seed = 32'h3f5d;
        rstn = 1'b0;
        wr = '0;
        trap = '0;
        hardware_int = '0;
        raddr_a = csr_pkg::CSR_CRMD;
        raddr_b = csr_pkg::CSR_CRMD;
        {chk_rd, chk_tr, chk_plv, chk_ecode, chk_era, chk_int, chk_tmr, chk_eentry} = '0;
        exp_a = '0;
        exp_b = '0;
        exp_era = '0;
        exp_eentry = '0;
        exp_plv = '0;
        exp_ecode = '0;
        exp_tr = csr_pkg::TR_DIRECT;
        exp_cpu = 1'b0;
        exp_idle = 1'b0;
        cyc = 0;
        t0 = 0;
        err_count = 0;
        err_mark = 0;
        pass_tests = 0;
        fail_tests = 0;
        for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
            save_m[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        // masked random scratch writes
        for (int n = 0; n < 12; n++) begin
            idx = {$random(seed)} % `CSR_NUM_SAVE;
            m = $random(seed);
            d = $random(seed);
            sw_write(csr_pkg::csr_addr_e'(csr_pkg::CSR_SAVE0 + idx), m, d);
            save_m[idx] = (save_m[idx] & ~m) | (d & m);
        end
        for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
            check_read(csr_pkg::csr_addr_e'(csr_pkg::CSR_SAVE0 + i), save_m[i],
                       csr_pkg::csr_addr_e'(csr_pkg::CSR_SAVE0 + `CSR_NUM_SAVE - 1 - i),
                       save_m[`CSR_NUM_SAVE - 1 - i]);
        end
        check_read(csr_pkg::csr_addr_e'(14'h3ff), 32'h0, csr_pkg::CSR_TICLR, 32'h0);
        end_test("save");

        // pg/da only change on a legal pair
        chk_tr = 1'b1;
        exp_tr = csr_pkg::TR_DIRECT;
        tick();
        sw_write(csr_pkg::CSR_CRMD, 32'h18, 32'h18);
        tick();
        sw_write(csr_pkg::CSR_CRMD, 32'h18, 32'h10);
        exp_tr = csr_pkg::TR_PAGED;
        tick();
        sw_write(csr_pkg::CSR_CRMD, 32'h08, 32'h08);
        tick();
        sw_write(csr_pkg::CSR_CRMD, 32'h18, 32'h08);
        exp_tr = csr_pkg::TR_DIRECT;
        tick();
        end_test("translate");

        // store then restore, then both at once
        sw_write(csr_pkg::CSR_CRMD, 32'h7, 32'h7);
        chk_plv = 1'b1;
        exp_plv = 2'd3;
        tick();
        trap.store = 1'b1;
        tick();
        trap.store = 1'b0;
        exp_plv = 2'd0;
        check_read(csr_pkg::CSR_CRMD, 32'h08, csr_pkg::CSR_PRMD, 32'h07);
        trap.restore = 1'b1;
        tick();
        trap.restore = 1'b0;
        exp_plv = 2'd3;
        check_read(csr_pkg::CSR_CRMD, 32'h0f, csr_pkg::CSR_PRMD, 32'h07);
        sw_write(csr_pkg::CSR_PRMD, 32'h7, 32'h1);
        trap.store = 1'b1;
        trap.restore = 1'b1;
        tick();
        trap = '0;
        exp_plv = 2'd1;
        check_read(csr_pkg::CSR_CRMD, 32'h09, csr_pkg::CSR_PRMD, 32'h07);
        chk_plv = 1'b0;
        end_test("trap");

        // subcode needs a nonzero code
        trap.ecode_we = 1'b1;
        trap.ecode = 7'h4a;
        tick();
        trap.ecode_we = 1'b0;
        chk_ecode = 1'b1;
        exp_ecode = 6'h0a;
        check_read(csr_pkg::CSR_ESTAT, (32'h0a << 16) | (32'h1 << 22), csr_pkg::CSR_ERA, 32'h0);
        trap.ecode_we = 1'b1;
        trap.ecode = 7'h40;
        tick();
        trap.ecode_we = 1'b0;
        exp_ecode = 6'h00;
        check_read(csr_pkg::CSR_ESTAT, 32'h0, csr_pkg::CSR_CRMD, 32'h09);
        chk_ecode = 1'b0;
        trap.era_we = 1'b1;
        trap.era = 32'h1234_5678;
        sw_write(csr_pkg::CSR_ERA, 32'hffff_ffff, $random(seed));
        trap = '0;
        chk_era = 1'b1;
        exp_era = 32'h1234_5678;
        check_read(csr_pkg::CSR_ERA, exp_era, csr_pkg::CSR_PRMD, 32'h07);
        sw_write(csr_pkg::CSR_ERA, 32'h0000_ffff, 32'hdead_beef);
        exp_era = 32'h1234_beef;
        check_read(csr_pkg::CSR_ERA, exp_era, csr_pkg::CSR_TICLR, 32'h0);
        chk_era = 1'b0;
        end_test("ecode_era");

        ////////////////////////////////////////////////////////////
        // periodic timer with a local enable on line 11
        sw_write(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        sw_write(csr_pkg::CSR_ECFG, 32'h800, 32'h800);
        t0 = cyc;
        chk_tmr = 1'b1;
        sw_write(csr_pkg::CSR_TCFG, 32'hffff_ffff, (TIMER_IV << 2) | 32'h3);
        wait_for_idle(LATENCY + 4);
        chk_int = 1'b1;
        exp_cpu = 1'b1;
        exp_idle = 1'b1;
        check_read(csr_pkg::CSR_ESTAT, 32'h800, csr_pkg::CSR_ECFG, 32'h800);
        chk_tmr = 1'b0;
        chk_int = 1'b0;
        sw_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        chk_int = 1'b1;
        exp_cpu = 1'b0;
        exp_idle = 1'b0;
        tick();
        chk_int = 1'b0;
        wait_for_idle(LATENCY + 4);
        sw_write(csr_pkg::CSR_CRMD, 32'h4, 32'h0);
        chk_int = 1'b1;
        exp_cpu = 1'b0;
        exp_idle = 1'b1;
        tick();
        chk_int = 1'b0;
        sw_write(csr_pkg::CSR_TCFG, 32'h1, 32'h0);
        sw_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        sw_write(csr_pkg::CSR_ECFG, 32'h800, 32'h0);
        end_test("timer");

        // hardware lines need no enable for idle wakeup
        // ie set but no lie, so cpu stays low
        sw_write(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        hardware_int = 8'ha5;
        chk_int = 1'b1;
        exp_cpu = 1'b0;
        exp_idle = 1'b1;
        check_read(csr_pkg::CSR_ESTAT, 32'ha5 << 2, csr_pkg::CSR_ECFG, 32'h0);
        hardware_int = 8'h00;
        exp_idle = 1'b0;
        check_read(csr_pkg::CSR_ESTAT, 32'h0, csr_pkg::CSR_TICLR, 32'h0);
        chk_int = 1'b0;
        end_test("hw_int");

        // eentry keeps bits 31:6 only
        chk_eentry = 1'b1;
        for (int n = 0; n < 4; n++) begin
            m = $random(seed);
            d = $random(seed);
            sw_write(csr_pkg::CSR_EENTRY, m, d);
            exp_eentry = ((exp_eentry & ~m) | (d & m)) & 32'hffff_ffc0;
            check_read(csr_pkg::CSR_EENTRY, exp_eentry, csr_pkg::CSR_EENTRY, exp_eentry);
        end
        chk_eentry = 1'b0;
        end_test("eentry");

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hw
hw/csr_pkg.sv
hw/csr_write_decode.sv
hw/csr_save_reg.sv
hw/csr_exc_state.sv
hw/csr_timer.sv
hw/csr_read_mux.sv
hw/csr_top.sv
dv/csr_tb.sv
